/* mmx_pkg.sv */
package mmx_pkg;

	// --------------------
	// Lane geometry
	// --------------------

	// Four words or two dwords in one MM register
	localparam int WORD_W      = 16;
	localparam int DWORD_W     = 32;
	localparam int WORD_LANES  = 4;
	localparam int DWORD_LANES = 2;

	// Architectural register count
	localparam int MM_REGS = 8;

	// --------------------
	// Data types
	// --------------------

	// One MM register value
	typedef logic [63:0] mmx_data_t;

	// MM register number
	typedef logic [2:0] mmx_reg_idx_t;

	// Immediate field, PSHUFW only looks at the low byte
	typedef logic [31:0] mmx_imm_t;

	// Single word lane
	typedef logic [WORD_W-1:0] mmx_word_t;

	// Issue opcodes
	typedef enum logic [2:0] {
		OP_PADDW  = 3'd0,
		OP_PADDD  = 3'd1,
		OP_PADDSW = 3'd2,
		OP_PSHUFW = 3'd3,
		OP_PASS_A = 3'd4,
		OP_PASS_B = 3'd5,
		OP_LOAD   = 3'd6,
		OP_RSVD   = 3'd7
	} mmx_op_t;

	// Adder lane behavior
	typedef enum logic [1:0] {
		LANE_WORD_WRAP  = 2'd0,
		LANE_DWORD_WRAP = 2'd1,
		LANE_WORD_SAT   = 2'd2
	} lane_mode_t;

	// Signed word clamp values
	localparam mmx_word_t WORD_SAT_MAX = 16'h7FFF;
	localparam mmx_word_t WORD_SAT_MIN = 16'h8000;

endpackage

/* mmx_if.sv */
`timescale 1ns/1ps

// One instruction per valid strobe, no ready
interface mmx_issue_if import mmx_pkg::*; ();
	logic         valid;
	mmx_op_t      op;
	// Destination register number
	mmx_reg_idx_t dst_idx;
	mmx_reg_idx_t src_a;
	mmx_reg_idx_t src_b;
	mmx_imm_t     imm;

	modport src (output valid, op, dst_idx, src_a, src_b, imm);
	modport dst (input valid, op, dst_idx, src_a, src_b, imm);
endinterface

// Register file access, two reads and one write
interface mmx_rf_if import mmx_pkg::*; ();
	mmx_reg_idx_t rd_idx_a;
	mmx_reg_idx_t rd_idx_b;
	mmx_data_t    rd_data_a;
	mmx_data_t    rd_data_b;
	logic         wr_en;
	mmx_reg_idx_t wr_idx;
	mmx_data_t    wr_data;

	modport pipe (output rd_idx_a, rd_idx_b, wr_en, wr_idx, wr_data,
		input rd_data_a, rd_data_b);
	modport rf (input rd_idx_a, rd_idx_b, wr_en, wr_idx, wr_data,
		output rd_data_a, rd_data_b);
endinterface

/* mmx_regfile.sv */
`timescale 1ns/1ps

module mmx_regfile import mmx_pkg::*; (
	input logic clk,
	input logic rst_n,
	mmx_rf_if.rf rf
);

	// Architectural MM0..MM7
	mmx_data_t regs [MM_REGS];

	// --------------------
	// Write port
	// --------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < MM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (rf.wr_en) begin
			regs[rf.wr_idx] <= rf.wr_data;
		end
	end

	// --------------------
	// Read ports
	// --------------------

	// Stored value only, the pipe handles in-flight results
	assign rf.rd_data_a = regs[rf.rd_idx_a];
	assign rf.rd_data_b = regs[rf.rd_idx_b];

	// Write address must be clean whenever a write is requested
	wr_idx_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		rf.wr_en |-> !$isunknown(rf.wr_idx)
	) else $error("mmx_regfile: wr_idx unknown during write");

endmodule

/* mmx_lane_adder.sv */
`timescale 1ns/1ps

module mmx_lane_adder import mmx_pkg::*; (
	input  mmx_data_t  a,
	input  mmx_data_t  b,
	input  lane_mode_t mode,
	output mmx_data_t  sum
);

	// Wrapped sum before any clamping
	mmx_data_t raw;

	// --------------------
	// Carry chain per dword
	// --------------------

	// Low word carry crosses into the high word only in dword mode
	for (genvar d = 0; d < DWORD_LANES; d++) begin : g_dword
		logic [WORD_W:0]   lo_sum;
		logic              hi_cin;
		logic [WORD_W-1:0] hi_sum;

		assign lo_sum = {1'b0, a[d*DWORD_W +: WORD_W]} + {1'b0, b[d*DWORD_W +: WORD_W]};
		assign hi_cin = (mode == LANE_DWORD_WRAP) ? lo_sum[WORD_W] : 1'b0;
		// Carry out of the high word is dropped
		assign hi_sum = a[d*DWORD_W + WORD_W +: WORD_W]
			+ b[d*DWORD_W + WORD_W +: WORD_W]
			+ {{(WORD_W-1){1'b0}}, hi_cin};
		assign raw[d*DWORD_W +: DWORD_W] = {hi_sum, lo_sum[WORD_W-1:0]};
	end

	// --------------------
	// Word saturation
	// --------------------

	for (genvar w = 0; w < WORD_LANES; w++) begin : g_sat
		logic a_sign;
		logic b_sign;
		logic r_sign;
		logic ovf;

		assign a_sign = a[w*WORD_W + WORD_W - 1];
		assign b_sign = b[w*WORD_W + WORD_W - 1];
		assign r_sign = raw[w*WORD_W + WORD_W - 1];

		// Same-sign inputs giving the other sign means overflow
		assign ovf = (mode == LANE_WORD_SAT) && (a_sign == b_sign) && (r_sign != a_sign);

		// Negative inputs clamp low, positive clamp high
		assign sum[w*WORD_W +: WORD_W] = ovf ? (a_sign ? WORD_SAT_MIN : WORD_SAT_MAX)
			: raw[w*WORD_W +: WORD_W];
	end

endmodule

/* mmx_alu.sv */
`timescale 1ns/1ps

module mmx_alu import mmx_pkg::*; (
	input  mmx_op_t   op,
	input  mmx_data_t mm_a,
	input  mmx_data_t mm_b,
	input  mmx_imm_t  imm,
	output mmx_data_t result
);

	lane_mode_t mode;
	mmx_data_t  add_sum;
	mmx_data_t  shuf;
	mmx_data_t  load_val;

	// --------------------
	// Packed add
	// --------------------

	// Non-add opcodes leave the adder in word wrap
	always_comb begin
		case (op)
			OP_PADDD:  mode = LANE_DWORD_WRAP;
			OP_PADDSW: mode = LANE_WORD_SAT;
			default:   mode = LANE_WORD_WRAP;
		endcase
	end

	mmx_lane_adder u_adder (
		.a    (mm_a),
		.b    (mm_b),
		.mode (mode),
		.sum  (add_sum)
	);

	// --------------------
	// Shuffle and load
	// --------------------

	// Result word i picks source B word imm[2i+1:2i]
	for (genvar i = 0; i < WORD_LANES; i++) begin : g_shuf
		logic [1:0] sel;

		assign sel = imm[2*i +: 2];
		assign shuf[i*WORD_W +: WORD_W] = mm_b[sel*WORD_W +: WORD_W];
	end

	// Immediate copied into both dword halves
	assign load_val = {imm, imm};

	// Final select
	always_comb begin
		case (op)
			OP_PADDW, OP_PADDD, OP_PADDSW: result = add_sum;
			OP_PSHUFW: result = shuf;
			OP_PASS_A: result = mm_a;
			OP_PASS_B: result = mm_b;
			OP_LOAD:   result = load_val;
			default:   result = '0;
		endcase
	end

	// Reserved opcode is never issued upstream
	always_comb begin
		assert final (op !== OP_RSVD) else $error("mmx_alu: reserved opcode at execute");
	end

endmodule

/* mmx_exec_pipe.sv */
`timescale 1ns/1ps

module mmx_exec_pipe import mmx_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	mmx_issue_if.dst     issue,
	mmx_rf_if.pipe       rf,
	output logic         result_valid,
	output mmx_reg_idx_t result_dst,
	output mmx_data_t    result_data
);

	// Read stage loaded at the issue edge
	logic         s1_valid;
	mmx_op_t      s1_op;
	mmx_reg_idx_t s1_dst;
	mmx_reg_idx_t s1_src_a;
	mmx_reg_idx_t s1_src_b;
	mmx_imm_t     s1_imm;

	// Execute stage with operands already resolved
	logic         ex_valid;
	mmx_op_t      ex_op;
	mmx_reg_idx_t ex_dst;
	mmx_imm_t     ex_imm;
	mmx_data_t    ex_a;
	mmx_data_t    ex_b;

	// Stage 2 holds the result and drives writeback
	logic         s2_valid;
	mmx_reg_idx_t s2_dst;
	mmx_data_t    s2_data;

	mmx_data_t alu_result;
	mmx_data_t opnd_a;
	mmx_data_t opnd_b;

	// --------------------
	// Operand read and bypass
	// --------------------

	assign rf.rd_idx_a = s1_src_a;
	assign rf.rd_idx_b = s1_src_b;

	// Execute result is younger than stage 2, so it wins
	always_comb begin
		opnd_a = rf.rd_data_a;
		if (s2_valid && s2_dst == s1_src_a)
			opnd_a = s2_data;
		if (ex_valid && ex_dst == s1_src_a)
			opnd_a = alu_result;
		opnd_b = rf.rd_data_b;
		if (s2_valid && s2_dst == s1_src_b)
			opnd_b = s2_data;
		if (ex_valid && ex_dst == s1_src_b)
			opnd_b = alu_result;
	end

	mmx_alu u_alu (
		.op     (ex_op),
		.mm_a   (ex_a),
		.mm_b   (ex_b),
		.imm    (ex_imm),
		.result (alu_result)
	);

	// --------------------
	// Pipeline registers
	// --------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s1_op    <= OP_PADDW;
			s1_dst   <= '0;
			s1_src_a <= '0;
			s1_src_b <= '0;
			s1_imm   <= '0;
			ex_valid <= 1'b0;
			ex_op    <= OP_PADDW;
			ex_dst   <= '0;
			ex_imm   <= '0;
			ex_a     <= '0;
			ex_b     <= '0;
			s2_valid <= 1'b0;
			s2_dst   <= '0;
			s2_data  <= '0;
		end else begin
			s1_valid <= issue.valid;
			// Fields only move with a valid instruction
			if (issue.valid) begin
				s1_op    <= issue.op;
				s1_dst   <= issue.dst_idx;
				s1_src_a <= issue.src_a;
				s1_src_b <= issue.src_b;
				s1_imm   <= issue.imm;
			end
			ex_valid <= s1_valid;
			if (s1_valid) begin
				ex_op  <= s1_op;
				ex_dst <= s1_dst;
				ex_imm <= s1_imm;
				ex_a   <= opnd_a;
				ex_b   <= opnd_b;
			end
			s2_valid <= ex_valid;
			if (ex_valid) begin
				s2_dst  <= ex_dst;
				s2_data <= alu_result;
			end
		end
	end

	// Writeback lands one edge after the result is shown
	assign rf.wr_en   = s2_valid;
	assign rf.wr_idx  = s2_dst;
	assign rf.wr_data = s2_data;

	assign result_valid = s2_valid;
	assign result_dst   = s2_dst;
	assign result_data  = s2_data;

	// Result and its destination show up two edges after the issue edge
	issue_to_result: assert property (
		@(posedge clk) disable iff (!rst_n)
		issue.valid |=> ##2 (result_valid && result_dst == $past(issue.dst_idx, 3))
	) else $error("mmx_exec_pipe: result missing or misdirected after issue");

	result_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		result_valid |-> !$isunknown({result_dst, result_data})
	) else $error("mmx_exec_pipe: unknown result while valid");

endmodule

/* mmx_unit.sv */
`timescale 1ns/1ps

module mmx_unit import mmx_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        issue_valid,
	input  logic [2:0]  issue_op,
	input  logic [2:0]  issue_dst,
	input  logic [2:0]  issue_src_a,
	input  logic [2:0]  issue_src_b,
	input  logic [31:0] issue_imm,
	output logic        result_valid,
	output logic [2:0]  result_dst,
	output logic [63:0] result_data
);

	mmx_issue_if issue_bus ();
	mmx_rf_if    rf_bus ();

	// --------------------
	// Issue port mapping
	// --------------------

	assign issue_bus.valid   = issue_valid;
	// Raw opcode bits onto the enum
	assign issue_bus.op      = mmx_op_t'(issue_op);
	assign issue_bus.dst_idx = issue_dst;
	assign issue_bus.src_a   = issue_src_a;
	assign issue_bus.src_b   = issue_src_b;
	assign issue_bus.imm     = issue_imm;

	// Pipe and register file
	mmx_exec_pipe u_pipe (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue        (issue_bus.dst),
		.rf           (rf_bus.pipe),
		.result_valid (result_valid),
		.result_dst   (result_dst),
		.result_data  (result_data)
	);

	mmx_regfile u_rf (
		.clk   (clk),
		.rst_n (rst_n),
		.rf    (rf_bus.rf)
	);

endmodule

/* tb_mmx_unit.sv */
`timescale 1ns/1ps

module tb_mmx_unit import mmx_pkg::*; ();

	logic        clk;
	logic        rst_n;
	logic        issue_valid;
	logic [2:0]  issue_op;
	logic [2:0]  issue_dst;
	logic [2:0]  issue_src_a;
	logic [2:0]  issue_src_b;
	logic [31:0] issue_imm;
	logic        result_valid;
	logic [2:0]  result_dst;
	logic [63:0] result_data;

	// Reference register file written at issue time
	mmx_data_t    model_rf [MM_REGS];
	// Expected results by age with entry 2 due at the output
	logic [2:0]   exp_valid;
	mmx_reg_idx_t exp_dst [3];
	mmx_data_t    exp_data [3];
	// Result of the instruction being driven now
	mmx_reg_idx_t next_dst;
	mmx_data_t    next_data;
	logic [31:0]  rng_state;
	int           err_count = 0;
	int           check_count = 0;
	int           cycle_count = 0;
	int           test_count = 0;
	int           test_fail_count = 0;

	mmx_unit dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.issue_valid  (issue_valid),
		.issue_op     (issue_op),
		.issue_dst    (issue_dst),
		.issue_src_a  (issue_src_a),
		.issue_src_b  (issue_src_b),
		.issue_imm    (issue_imm),
		.result_valid (result_valid),
		.result_dst   (result_dst),
		.result_data  (result_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------
	// Reference model
	// --------------------

	function automatic mmx_data_t model_exec(input mmx_op_t op, input mmx_data_t a,
		input mmx_data_t b, input mmx_imm_t imm);
		mmx_data_t r;
		int        s;
		r = '0;
		case (op)
			OP_PADDW: for (int i = 0; i < 4; i++) r[16*i +: 16] = a[16*i +: 16] + b[16*i +: 16];
			OP_PADDD: for (int i = 0; i < 2; i++) r[32*i +: 32] = a[32*i +: 32] + b[32*i +: 32];
			OP_PADDSW: begin
				// Full signed sum, then clamp to the word range
				for (int i = 0; i < 4; i++) begin
					s = int'($signed(a[16*i +: 16])) + int'($signed(b[16*i +: 16]));
					if (s > 32767)
						s = 32767;
					else if (s < -32768)
						s = -32768;
					r[16*i +: 16] = 16'(s);
				end
			end
			OP_PSHUFW: for (int i = 0; i < 4; i++) r[16*i +: 16] = b[16*imm[2*i +: 2] +: 16];
			OP_PASS_A: r = a;
			OP_PASS_B: r = b;
			OP_LOAD:   r = {imm, imm};
			default:   r = '0;
		endcase
		return r;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Age the expectations in step with the DUT pipe
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_valid <= 3'b000;
			for (int i = 0; i < 3; i++) begin
				exp_dst[i]  <= '0;
				exp_data[i] <= '0;
			end
		end else begin
			exp_valid   <= {exp_valid[1:0], issue_valid};
			exp_dst[0]  <= next_dst;
			exp_data[0] <= next_data;
			for (int i = 1; i < 3; i++) begin
				exp_dst[i]  <= exp_dst[i-1];
				exp_data[i] <= exp_data[i-1];
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (rst_n && result_valid)
			check_count <= check_count + 1;
	end

	// --------------------
	// Output checks
	// --------------------

	task automatic report_value(input string name, input logic [63:0] expv,
		input logic [63:0] actv);
		$display("FAILED at %0t: %s expected %h, got %h", $time, name, expv, actv);
		err_count++;
	endtask

	// Quiet output while reset is held
	reset_quiet: assert property (@(posedge clk) (!rst_n && cycle_count > 0) |-> !result_valid)
		else report_value("result_valid", 64'(0), 64'($sampled(result_valid)));

	valid_match: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid == exp_valid[2])
		else report_value("result_valid", 64'($sampled(exp_valid[2])),
			64'($sampled(result_valid)));

	dst_match: assert property (@(posedge clk) disable iff (!rst_n)
		(result_valid && exp_valid[2]) |-> result_dst == exp_dst[2])
		else report_value("result_dst", 64'($sampled(exp_dst[2])), 64'($sampled(result_dst)));

	data_match: assert property (@(posedge clk) disable iff (!rst_n)
		(result_valid && exp_valid[2]) |-> result_data == exp_data[2])
		else report_value("result_data", $sampled(exp_data[2]), $sampled(result_data));

	// --------------------
	// Stimulus helpers
	// --------------------

	// One instruction for one cycle with the model updated at once
	task automatic issue_instr(input mmx_op_t op, input mmx_reg_idx_t dst,
		input mmx_reg_idx_t src_a, input mmx_reg_idx_t src_b, input mmx_imm_t imm);
		next_data     = model_exec(op, model_rf[src_a], model_rf[src_b], imm);
		next_dst      = dst;
		model_rf[dst] = next_data;
		issue_valid   = 1'b1;
		issue_op      = op;
		issue_dst     = dst;
		issue_src_a   = src_a;
		issue_src_b   = src_b;
		issue_imm     = imm;
		@(posedge clk);
		#1;
		issue_valid = 1'b0;
	endtask

	// Random registers and immediate for a given opcode
	task automatic issue_random(input mmx_op_t op);
		logic [31:0] regs;
		rng_state = xorshift32(rng_state);
		regs      = rng_state;
		rng_state = xorshift32(rng_state);
		issue_instr(op, regs[10:8], regs[13:11], regs[16:14], rng_state);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Spread random values over all registers
	task automatic seed_registers();
		for (int r = 0; r < MM_REGS; r++) begin
			rng_state = xorshift32(rng_state);
			issue_instr(OP_LOAD, 3'(r), 3'(r), 3'(r), rng_state);
			rng_state = xorshift32(rng_state);
			issue_instr(OP_PSHUFW, 3'(r), 3'(r), 3'(r), rng_state);
		end
		for (int r = 0; r < MM_REGS; r++)
			issue_instr(OP_PADDD, 3'(r), 3'(r), 3'((r + 3) % MM_REGS), '0);
	endtask

	// Let in-flight results reach the checks, then report the test
	task automatic finish_test(input string name, input int err_before);
		int waited;
		waited = 0;
		while ((exp_valid != 3'b000 || result_valid) && waited < 20) begin
			@(posedge clk);
			#1;
			waited++;
		end
		test_count++;
		if (exp_valid != 3'b000 || result_valid) begin
			// Pipe never emptied within the limit
			test_fail_count++;
			$display("test %s: failed as its results never drained", name);
		end else if (err_count != err_before) begin
			test_fail_count++;
			$display("test %s: failed with %0d errors", name, err_count - err_before);
		end else begin
			$display("test %s: passed", name);
		end
	endtask

	// --------------------
	// Test sequence
	// --------------------

	initial begin
		int e;
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue_op    = '0;
		issue_dst   = '0;
		issue_src_a = '0;
		issue_src_b = '0;
		issue_imm   = '0;
		next_dst    = '0;
		next_data   = '0;
		rng_state   = 32'd89947;
		for (int r = 0; r < MM_REGS; r++)
			model_rf[r] = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Idle output, then every register reads zero
		e = err_count;
		idle_cycles(4);
		for (int r = 0; r < MM_REGS; r++)
			issue_instr(OP_PASS_A, 3'(r), 3'(r), 3'((r + 1) % MM_REGS), '0);
		finish_test("reset_idle", e);

		e = err_count;
		issue_instr(OP_LOAD, 3'd1, 3'd0, 3'd0, 32'h1234_5678);
		issue_instr(OP_LOAD, 3'd2, 3'd0, 3'd0, 32'h9ABC_DEF0);
		idle_cycles(2);
		issue_instr(OP_PASS_A, 3'd3, 3'd1, 3'd2, '0);
		idle_cycles(1);
		issue_instr(OP_PASS_B, 3'd4, 3'd1, 3'd2, '0);
		finish_test("load_pass", e);

		// Lane carries must not cross lane boundaries
		e = err_count;
		issue_instr(OP_LOAD, 3'd0, 3'd0, 3'd0, 32'hFFFF_FFFF);
		issue_instr(OP_LOAD, 3'd1, 3'd0, 3'd0, 32'h0001_0001);
		issue_instr(OP_LOAD, 3'd3, 3'd0, 3'd0, 32'h0000_0001);
		issue_instr(OP_PADDW, 3'd2, 3'd0, 3'd1, '0);
		issue_instr(OP_PADDD, 3'd4, 3'd0, 3'd3, '0);
		seed_registers();
		repeat (20) begin
			issue_random(OP_PADDW);
			issue_random(OP_PADDD);
		end
		finish_test("wrap_add", e);

		e = err_count;
		issue_instr(OP_LOAD, 3'd0, 3'd0, 3'd0, 32'h7000_7000);
		issue_instr(OP_LOAD, 3'd2, 3'd0, 3'd0, 32'h8000_8000);
		issue_instr(OP_LOAD, 3'd3, 3'd0, 3'd0, 32'hFFFF_FFFF);
		issue_instr(OP_LOAD, 3'd5, 3'd0, 3'd0, 32'h7000_9000);
		issue_instr(OP_PADDSW, 3'd1, 3'd0, 3'd0, '0);
		issue_instr(OP_PADDSW, 3'd4, 3'd2, 3'd3, '0);
		// Mixed signs never clamp
		issue_instr(OP_PADDSW, 3'd6, 3'd0, 3'd2, '0);
		issue_instr(OP_PADDSW, 3'd7, 3'd5, 3'd3, '0);
		finish_test("saturate", e);

		e = err_count;
		seed_registers();
		issue_instr(OP_PSHUFW, 3'd1, 3'd0, 3'd2, 32'h0000_001B);
		issue_instr(OP_PSHUFW, 3'd3, 3'd0, 3'd4, 32'h0000_0000);
		repeat (20) issue_random(OP_PSHUFW);
		finish_test("shuffle", e);

		// Chains that read the last and second-to-last results
		e = err_count;
		rng_state = xorshift32(rng_state);
		issue_instr(OP_LOAD, 3'd1, 3'd0, 3'd0, rng_state);
		issue_instr(OP_PADDW, 3'd2, 3'd1, 3'd1, '0);
		issue_instr(OP_PADDD, 3'd3, 3'd2, 3'd1, '0);
		issue_instr(OP_PADDSW, 3'd1, 3'd3, 3'd2, '0);
		issue_instr(OP_PSHUFW, 3'd4, 3'd0, 3'd1, 32'h0000_00E4);
		issue_instr(OP_PASS_A, 3'd5, 3'd4, 3'd0, '0);
		issue_instr(OP_PASS_B, 3'd6, 3'd0, 3'd4, '0);
		repeat (200) begin
			rng_state = xorshift32(rng_state);
			issue_random(mmx_op_t'(3'(rng_state % 7)));
		end
		finish_test("dependent_stream", e);

		$display("%0d tests, %0d failed, %0d results checked, %0d errors",
			test_count, test_fail_count, check_count, err_count);
		if (err_count == 0 && test_fail_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* sim.f */
mmx_pkg.sv
mmx_if.sv
mmx_regfile.sv
mmx_lane_adder.sv
mmx_alu.sv
mmx_exec_pipe.sv
mmx_unit.sv
tb_mmx_unit.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --assert --timing -j 0
TOP       = tb_mmx_unit
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

SRCS = $(filter-out +%,$(shell cat $(FILELIST)))
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
